//--- hw/tinker_pkg.sv
package tinker_pkg;

    // machine widths
    parameter int xlen  = 64;  // register and result width
    parameter int ilen  = 32;  // instruction word
    parameter int lit_w = 12;  // literal field
    parameter int nregs = 32;

    typedef logic [xlen-1:0]          data_t;
    typedef logic [ilen-1:0]          instr_t;
    typedef logic [$clog2(nregs)-1:0] reg_idx_t;
    typedef logic [lit_w-1:0]         lit_t;

    // integer opcodes, memory, branch and float codes are not part of this slice
    typedef enum logic [4:0] {
        op_and    = 5'b00000,
        op_or     = 5'b00001,
        op_xor    = 5'b00010,
        op_not    = 5'b00011,
        op_shftr  = 5'b00100,
        op_shftri = 5'b00101,
        op_shftl  = 5'b00110,
        op_shftli = 5'b00111,
        op_halt   = 5'b01111,
        op_mov    = 5'b10001,  // mov rd, rs
        op_mov_l  = 5'b10010,  // mov_L_to_reg
        op_add    = 5'b11000,
        op_addi   = 5'b11001,
        op_sub    = 5'b11010,
        op_subi   = 5'b11011,
        op_mul    = 5'b11100,
        op_div    = 5'b11101
    } opcode_t;

    // handshake sequencing in decode
    typedef enum logic [1:0] {
        st_idle,     // waiting for req
        st_execute,  // operands read, execute registers result
        st_retire,   // write-back happens at the end of this cycle
        st_release   // ack high until req goes away
    } decode_state_t;

endpackage

//--- hw/tinker_decode.sv
`timescale 1ns/100ps

module tinker_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_req,
    input  tinker_pkg::instr_t   in_instr,
    input  logic                 hlt,
    output logic                 in_ack,
    output logic                 issue,
    output tinker_pkg::opcode_t  opcode,
    output tinker_pkg::reg_idx_t rd,
    output tinker_pkg::reg_idx_t rs,
    output tinker_pkg::reg_idx_t rt,
    output tinker_pkg::lit_t     lit
);
    import tinker_pkg::*;

    decode_state_t state;
    instr_t        instr_q;   // captured word
    logic          req_q;     // in_req as seen at the previous edge
    logic          accept;

    // a halted core takes nothing more
    assign accept = (state == st_idle) && in_req && !hlt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= st_idle;
            in_ack <= 1'b0;
            issue  <= 1'b0;
            req_q  <= 1'b0;
        end else begin
            req_q <= in_req;
            issue <= 1'b0;  // single-cycle strobe
            case (state)
                st_idle: begin
                    if (accept) begin
                        issue <= 1'b1;
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    state <= st_retire;
                end
                st_retire: begin
                    in_ack <= 1'b1;  // same edge as the write-back
                    state  <= st_release;
                end
                st_release: begin
                    // req was low at the last edge, so drop ack now
                    if (!req_q) begin
                        in_ack <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= in_instr;
        end
    end

    // field split of the held word
    assign opcode = opcode_t'(instr_q[31:27]);
    assign rd     = instr_q[26:22];
    assign rs     = instr_q[21:17];
    assign rt     = instr_q[16:12];
    assign lit    = instr_q[11:0];

    // ack may only come up for a request that is still there
    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req)
    );

endmodule

//--- hw/tinker_regfile.sv
`timescale 1ns/100ps

module tinker_regfile #(
    parameter tinker_pkg::data_t stack_top = 64'h80000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  tinker_pkg::reg_idx_t wr_reg,
    input  tinker_pkg::data_t    wr_data,
    input  tinker_pkg::reg_idx_t rs,
    input  tinker_pkg::reg_idx_t rt,
    input  tinker_pkg::reg_idx_t rd,
    output tinker_pkg::data_t    rs_val,
    output tinker_pkg::data_t    rt_val,
    output tinker_pkg::data_t    rd_val
);
    import tinker_pkg::*;

    data_t regs [nregs];

    // r0 is a normal register here, only r31 has a nonzero start value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < nregs - 1; i++) begin
                regs[i] <= '0;
            end
            regs[nregs-1] <= stack_top;  // stack pointer
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // three combinational read ports
    assign rs_val = regs[rs];
    assign rt_val = regs[rt];
    assign rd_val = regs[rd];  // addi, subi and mov_L read rd

endmodule

//--- hw/tinker_execute.sv
`timescale 1ns/100ps

module tinker_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  tinker_pkg::opcode_t  opcode,
    input  tinker_pkg::reg_idx_t rd,
    input  tinker_pkg::lit_t     lit,
    input  tinker_pkg::data_t    rs_val,
    input  tinker_pkg::data_t    rt_val,
    input  tinker_pkg::data_t    rd_val,
    output logic                 ex_valid,
    output logic                 ex_write,
    output logic                 ex_halt,
    output tinker_pkg::reg_idx_t ex_reg,
    output tinker_pkg::data_t    ex_data
);
    import tinker_pkg::*;

    localparam int sh_w = $clog2(xlen);  // useful shift amount bits

    data_t lit_sext;
    data_t op_a;
    data_t op_b;
    data_t alu_result;
    logic  alu_write;
    logic  alu_halt;
    logic  shift_big;

    assign lit_sext  = {{(xlen-lit_w){lit[lit_w-1]}}, lit};
    assign shift_big = (op_b >= data_t'(xlen));  // shifts everything out

    // operand mux
    always_comb begin
        op_a = rs_val;
        op_b = rt_val;
        case (opcode)
            op_addi, op_subi: begin
                op_a = rd_val;  // rd += L style
                op_b = lit_sext;
            end
            op_shftri, op_shftli: begin
                op_b = lit_sext;
            end
            default: begin
                op_b = rt_val;
            end
        endcase
    end

    always_comb begin
        alu_result = '0;
        alu_write  = 1'b1;
        alu_halt   = 1'b0;
        case (opcode)
            op_add, op_addi:     alu_result = op_a + op_b;
            op_sub, op_subi:     alu_result = op_a - op_b;
            op_mul:              alu_result = op_a * op_b;  // low 64 bits
            op_div:              alu_result = (op_b == '0) ? '1 : op_a / op_b;
            op_and:              alu_result = op_a & op_b;
            op_or:               alu_result = op_a | op_b;
            op_xor:              alu_result = op_a ^ op_b;
            op_not:              alu_result = ~op_a;
            op_shftr, op_shftri: alu_result = shift_big ? '0 : op_a >> op_b[sh_w-1:0];
            op_shftl, op_shftli: alu_result = shift_big ? '0 : op_a << op_b[sh_w-1:0];
            op_mov:              alu_result = op_a;
            op_mov_l:            alu_result = {rd_val[xlen-1:lit_w], lit};  // raw literal
            op_halt: begin
                alu_write = 1'b0;
                alu_halt  = 1'b1;
            end
            default: begin
                alu_write = 1'b0;  // unknown code retires silently
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_write <= 1'b0;
            ex_halt  <= 1'b0;
        end else begin
            ex_valid <= issue;
            if (issue) begin
                ex_write <= alu_write;
                ex_halt  <= alu_halt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ex_reg  <= rd;
            ex_data <= alu_result;
        end
    end

    // one instruction in flight means a lone issue strobe
    issue_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        issue |=> !issue
    );

endmodule

//--- hw/tinker_result.sv
`timescale 1ns/100ps

module tinker_result (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ex_valid,
    input  logic                 ex_write,
    input  logic                 ex_halt,
    input  tinker_pkg::reg_idx_t ex_reg,
    input  tinker_pkg::data_t    ex_data,
    output logic                 wr_en,
    output tinker_pkg::reg_idx_t wr_reg,
    output tinker_pkg::data_t    wr_data,
    output logic                 wb_valid,
    output tinker_pkg::reg_idx_t wb_reg,
    output tinker_pkg::data_t    wb_data,
    output logic                 hlt
);
    import tinker_pkg::*;

    // register file write lands on the same edge as the report
    assign wr_en   = ex_valid && ex_write;
    assign wr_reg  = ex_reg;
    assign wr_data = ex_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
            hlt      <= 1'b0;
        end else begin
            wb_valid <= wr_en;  // one pulse per write
            if (ex_valid && ex_halt) begin
                hlt <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wb_reg  <= ex_reg;
            wb_data <= ex_data;
        end
    end

    // each retired write is reported exactly once
    wb_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        wb_valid |=> !wb_valid
    );

endmodule

//--- hw/tinker_core.sv
`timescale 1ns/100ps

module tinker_core #(
    parameter tinker_pkg::data_t stack_top = 64'h80000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_req,
    input  tinker_pkg::instr_t   in_instr,
    output logic                 in_ack,
    output logic                 wb_valid,
    output tinker_pkg::reg_idx_t wb_reg,
    output tinker_pkg::data_t    wb_data,
    output logic                 hlt
);
    import tinker_pkg::*;

    // decode to register file and execute
    logic     issue;
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    lit_t     lit;
    data_t    rs_val;
    data_t    rt_val;
    data_t    rd_val;

    // execute to result
    logic     ex_valid;
    logic     ex_write;
    logic     ex_halt;
    reg_idx_t ex_reg;
    data_t    ex_data;

    // result back into the register file
    logic     wr_en;
    reg_idx_t wr_reg;
    data_t    wr_data;

    tinker_decode decode_i (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_instr (in_instr),
        .hlt      (hlt),
        .in_ack   (in_ack),
        .issue    (issue),
        .opcode   (opcode),
        .rd       (rd),
        .rs       (rs),
        .rt       (rt),
        .lit      (lit)
    );

    tinker_regfile #(
        .stack_top (stack_top)
    ) regfile_i (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_reg   (wr_reg),
        .wr_data  (wr_data),
        .rs       (rs),
        .rt       (rt),
        .rd       (rd),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .rd_val   (rd_val)
    );

    tinker_execute execute_i (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .opcode   (opcode),
        .rd       (rd),
        .lit      (lit),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .rd_val   (rd_val),
        .ex_valid (ex_valid),
        .ex_write (ex_write),
        .ex_halt  (ex_halt),
        .ex_reg   (ex_reg),
        .ex_data  (ex_data)
    );

    tinker_result result_i (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_write (ex_write),
        .ex_halt  (ex_halt),
        .ex_reg   (ex_reg),
        .ex_data  (ex_data),
        .wr_en    (wr_en),
        .wr_reg   (wr_reg),
        .wr_data  (wr_data),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .hlt      (hlt)
    );

endmodule

//--- bench/tinker_tb.sv
`timescale 1ns/100ps

module tinker_tb;
    import tinker_pkg::*;

    localparam data_t stack_top    = 64'h0000_0000_0020_0000;  // r31 start value
    localparam int    num_rows     = 37;
    localparam int    reset_cycles = 10;
    localparam int    timeout_cycles = reset_cycles + num_rows * 8 + 20;
    localparam time   drive_delay  = 1;

    logic     clk;
    logic     reset;
    logic     in_req;
    instr_t   in_instr;
    logic     in_ack;
    logic     wb_valid;
    reg_idx_t wb_reg;
    data_t    wb_data;
    logic     hlt;

    // stimulus table with one row per instruction
    instr_t   tbl_instr [num_rows];
    logic     tbl_write [num_rows];
    reg_idx_t tbl_reg   [num_rows];
    data_t    tbl_data  [num_rows];
    logic     tbl_halt  [num_rows];
    int       row_count = 0;
    int       cur_row   = -1;
    int       cycle_count = 0;

    tinker_core #(
        .stack_top (stack_top)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_instr (in_instr),
        .in_ack   (in_ack),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .hlt      (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d clock cycles", timeout_cycles);
            $display("Errors found");
            $fatal(1);
        end
    end

    // opcode | rd | rs | rt | literal
    function automatic instr_t encode_instr(input logic [4:0] op, input reg_idx_t rd,
                                            input reg_idx_t rs, input reg_idx_t rt,
                                            input lit_t lit);
        return {op, rd, rs, rt, lit};
    endfunction

    task automatic add_row(input instr_t instr, input logic wr, input reg_idx_t rg,
                           input data_t val, input logic hl);
        tbl_instr[row_count] = instr;
        tbl_write[row_count] = wr;
        tbl_reg[row_count]   = rg;
        tbl_data[row_count]  = val;
        tbl_halt[row_count]  = hl;
        row_count++;
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h got %h (row %0d)", name, expected, actual, cur_row);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected,
                             input reg_idx_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h got %h (row %0d)", name, expected, actual, cur_row);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s expected %h got %h (row %0d)", name, expected, actual, cur_row);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // sample just after the edge where outputs have settled
    task automatic wait_for_ack(input logic level);
        do begin
            @(posedge clk);
            #drive_delay;
        end while (in_ack !== level);
    endtask

    initial begin
        reset    = 1'b1;
        in_req   = 1'b0;
        in_instr = '0;

        // r31 and reset values
        add_row(encode_instr(op_mov, 1, 31, 0, 0), 1'b1, 1, stack_top, 1'b0);
        add_row(encode_instr(op_mov, 2, 5, 0, 0), 1'b1, 2, 64'h0, 1'b0);
        // arithmetic with addi and subi accumulating into rd
        add_row(encode_instr(op_addi, 2, 0, 0, 12'h064), 1'b1, 2, 64'h64, 1'b0);
        add_row(encode_instr(op_addi, 3, 0, 0, 12'h7ff), 1'b1, 3, 64'h7ff, 1'b0);
        add_row(encode_instr(op_subi, 3, 0, 0, 12'hfff), 1'b1, 3, 64'h800, 1'b0);  // minus -1
        add_row(encode_instr(op_addi, 4, 0, 0, 12'h800), 1'b1, 4, 64'hffff_ffff_ffff_f800, 1'b0);
        add_row(encode_instr(op_add, 5, 2, 3, 0), 1'b1, 5, 64'h864, 1'b0);
        add_row(encode_instr(op_sub, 6, 2, 3, 0), 1'b1, 6, 64'hffff_ffff_ffff_f864, 1'b0);
        add_row(encode_instr(op_mul, 7, 5, 4, 0), 1'b1, 7, 64'hffff_ffff_ffbc_e000, 1'b0);
        add_row(encode_instr(op_mul, 8, 1, 1, 0), 1'b1, 8, 64'h0000_0400_0000_0000, 1'b0);
        add_row(encode_instr(op_mul, 9, 8, 6, 0), 1'b1, 9, 64'hffe1_9000_0000_0000, 1'b0);
        add_row(encode_instr(op_div, 10, 8, 1, 0), 1'b1, 10, 64'h20_0000, 1'b0);
        add_row(encode_instr(op_div, 11, 5, 2, 0), 1'b1, 11, 64'h15, 1'b0);
        add_row(encode_instr(op_div, 12, 4, 3, 0), 1'b1, 12, 64'h001f_ffff_ffff_ffff, 1'b0);
        add_row(encode_instr(op_div, 13, 5, 0, 0), 1'b1, 13, '1, 1'b0);  // r0 still zero
        // logic
        add_row(encode_instr(op_and, 14, 5, 3, 0), 1'b1, 14, 64'h800, 1'b0);
        add_row(encode_instr(op_or, 15, 2, 8, 0), 1'b1, 15, 64'h0000_0400_0000_0064, 1'b0);
        add_row(encode_instr(op_xor, 16, 6, 7, 0), 1'b1, 16, 64'h0000_0000_0043_1864, 1'b0);
        add_row(encode_instr(op_not, 17, 5, 0, 0), 1'b1, 17, 64'hffff_ffff_ffff_f79b, 1'b0);
        // shifts
        add_row(encode_instr(op_addi, 18, 0, 0, 12'h004), 1'b1, 18, 64'h4, 1'b0);
        add_row(encode_instr(op_shftr, 19, 8, 18, 0), 1'b1, 19, 64'h0000_0040_0000_0000, 1'b0);
        add_row(encode_instr(op_shftl, 20, 7, 18, 0), 1'b1, 20, 64'hffff_ffff_fbce_0000, 1'b0);
        add_row(encode_instr(op_shftri, 21, 6, 0, 12'h008), 1'b1, 21, 64'h00ff_ffff_ffff_fff8,
                1'b0);
        add_row(encode_instr(op_shftli, 22, 5, 0, 12'h034), 1'b1, 22, 64'h8640_0000_0000_0000,
                1'b0);
        add_row(encode_instr(op_addi, 23, 0, 0, 12'h040), 1'b1, 23, 64'h40, 1'b0);
        add_row(encode_instr(op_shftr, 24, 6, 23, 0), 1'b1, 24, 64'h0, 1'b0);  // by 64
        add_row(encode_instr(op_shftli, 25, 17, 0, 12'h03f), 1'b1, 25, 64'h8000_0000_0000_0000,
                1'b0);
        add_row(encode_instr(op_shftli, 26, 6, 0, 12'h040), 1'b1, 26, 64'h0, 1'b0);
        // moves
        add_row(encode_instr(op_mov, 27, 9, 0, 0), 1'b1, 27, 64'hffe1_9000_0000_0000, 1'b0);
        add_row(encode_instr(op_mov, 28, 17, 0, 0), 1'b1, 28, 64'hffff_ffff_ffff_f79b, 1'b0);
        add_row(encode_instr(op_mov_l, 28, 0, 0, 12'h123), 1'b1, 28, 64'hffff_ffff_ffff_f123,
                1'b0);
        add_row(encode_instr(op_mov_l, 8, 0, 0, 12'habc), 1'b1, 8, 64'h0000_0400_0000_0abc, 1'b0);
        // unknown codes retire without a write
        add_row(encode_instr(5'b01000, 2, 5, 6, 0), 1'b0, 0, 64'h0, 1'b0);
        add_row(encode_instr(op_mov, 29, 2, 0, 0), 1'b1, 29, 64'h64, 1'b0);
        add_row(encode_instr(5'b10011, 3, 0, 0, 12'h7ff), 1'b0, 0, 64'h0, 1'b0);
        add_row(encode_instr(op_mov, 30, 3, 0, 0), 1'b1, 30, 64'h800, 1'b0);
        add_row(encode_instr(op_halt, 0, 0, 0, 0), 1'b0, 0, 64'h0, 1'b1);

        if (row_count != num_rows) begin
            $display("stimulus table holds %0d rows instead of %0d", row_count, num_rows);
            $display("Errors found");
            $fatal(1);
        end

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        check_flag("in_ack", 1'b0, in_ack);
        check_flag("wb_valid", 1'b0, wb_valid);
        check_flag("hlt", 1'b0, hlt);

        for (int i = 0; i < num_rows; i++) begin
            cur_row  = i;
            in_instr = tbl_instr[i];
            in_req   = 1'b1;
            wait_for_ack(1'b1);
            check_flag("wb_valid", tbl_write[i], wb_valid);  // pulse lines up with ack
            if (tbl_write[i]) begin
                check_reg("wb_reg", tbl_reg[i], wb_reg);
                check_data("wb_data", tbl_data[i], wb_data);
            end
            check_flag("hlt", tbl_halt[i], hlt);
            in_req = 1'b0;
            wait_for_ack(1'b0);
        end

        // halted core must ignore this one
        in_instr = encode_instr(op_mov, 1, 2, 0, 0);
        in_req   = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #drive_delay;
            if (in_ack !== 1'b0) begin
                $display("core acknowledged a request after halt");
                $display("Errors found");
                $fatal(1);
            end
        end
        in_req = 1'b0;
        @(posedge clk);

        $display("No errors");
        $finish;
    end

endmodule

//--- flist.f
hw/tinker_pkg.sv
hw/tinker_decode.sv
hw/tinker_regfile.sv
hw/tinker_execute.sv
hw/tinker_result.sv
hw/tinker_core.sv
bench/tinker_tb.sv
